// ==== rtl/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Byte address width of the fetch path
`define FETCH_ADDR_W 32

// One fetch word holds two 32-bit instructions
`define FETCH_WORD_W 64

// Direct-mapped, power of two
`define FETCH_BTC_ENTRIES 16

// First fetch address out of reset
`define FETCH_RESET_PC 32'h0000_1000

`endif

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] addr_t;
  typedef logic [`FETCH_WORD_W-1:0] word_t;
  typedef logic [$clog2(`FETCH_BTC_ENTRIES)-1:0] btc_index_t;

  // Wishbone classic, read only
  typedef struct packed {
    logic  cyc;
    logic  stb;
    addr_t adr;
  } wb_req_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

  // Back-end redirects, highest priority first
  typedef struct packed {
    logic  trap;
    addr_t trap_pc;
    logic  mret;
    addr_t mret_pc;
    logic  miss;
    addr_t miss_pc;
    logic  fence;
    addr_t fence_pc;
  } redirect_t;

  // Resolved branch from execute
  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t target;
  } btc_update_t;

  typedef struct packed {
    logic  hit;
    addr_t target;
  } btc_lookup_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    word_t instr;
    logic  taken;
    addr_t target;
  } fetch_packet_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DISCARD,
    SWEEP
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_control (
  input  logic                    clock,
  input  logic                    reset,
  output fetch_pkg::wb_req_t      wb_req,
  input  fetch_pkg::wb_rsp_t      wb_rsp,
  input  fetch_pkg::addr_t        fetch_pc,
  input  fetch_pkg::btc_lookup_t  lookup,
  input  logic                    redirect_pending,
  input  logic                    fence_request,
  input  logic                    sweep_done,
  input  logic                    stall,
  output logic                    advance,
  output logic                    sweep_start,
  output fetch_pkg::fetch_packet_t packet
);

  fetch_pkg::fetch_state_t  state;
  fetch_pkg::fetch_state_t  state_next;
  fetch_pkg::wb_req_t       req_q;
  fetch_pkg::wb_req_t       req_next;
  fetch_pkg::fetch_packet_t packet_q;
  fetch_pkg::fetch_packet_t packet_next;
  logic                     primed;
  logic                     fence_wait;
  logic                     fence_wait_next;
  logic                     packet_waiting;

  // Decode has not taken the current packet yet
  assign packet_waiting = packet_q.valid && stall;

  always_comb begin
    state_next = state;
    req_next = req_q;
    packet_next = packet_q;
    packet_next.valid = packet_waiting && !redirect_pending;
    fence_wait_next = fence_wait || (fence_request && state != fetch_pkg::SWEEP);
    advance = 1'b0;
    sweep_start = 1'b0;

    case (state)
      fetch_pkg::IDLE: begin
        if (fence_wait_next) begin
          state_next = fetch_pkg::SWEEP;
          sweep_start = 1'b1;
          fence_wait_next = 1'b0;
        end else if (primed && !redirect_pending && !packet_waiting) begin
          state_next = fetch_pkg::BUSY;
          req_next.cyc = 1'b1;
          req_next.stb = 1'b1;
          req_next.adr = fetch_pc;
        end
      end
      fetch_pkg::BUSY: begin
        if (wb_rsp.ack) begin
          req_next.cyc = 1'b0;
          req_next.stb = 1'b0;
          if (fence_wait_next) begin
            state_next = fetch_pkg::SWEEP;
            sweep_start = 1'b1;
            fence_wait_next = 1'b0;
          end else if (redirect_pending) begin
            // Data is on the wrong path
            state_next = fetch_pkg::IDLE;
          end else begin
            state_next = fetch_pkg::IDLE;
            advance = 1'b1;
            packet_next.valid = 1'b1;
            packet_next.pc = req_q.adr;
            packet_next.instr = wb_rsp.dat;
            packet_next.taken = lookup.hit;
            packet_next.target = lookup.hit ? lookup.target : '0;
          end
        end else if (redirect_pending) begin
          state_next = fetch_pkg::DISCARD;
        end
      end
      fetch_pkg::DISCARD: begin
        // Let the bus finish, then drop the word
        if (wb_rsp.ack) begin
          req_next.cyc = 1'b0;
          req_next.stb = 1'b0;
          if (fence_wait_next) begin
            state_next = fetch_pkg::SWEEP;
            sweep_start = 1'b1;
            fence_wait_next = 1'b0;
          end else begin
            state_next = fetch_pkg::IDLE;
          end
        end
      end
      fetch_pkg::SWEEP: begin
        if (sweep_done) begin
          if (redirect_pending) begin
            state_next = fetch_pkg::IDLE;
          end else begin
            state_next = fetch_pkg::BUSY;
            req_next.cyc = 1'b1;
            req_next.stb = 1'b1;
            req_next.adr = fetch_pc;
          end
        end
      end
      default: begin
        state_next = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch_pkg::IDLE;
      primed <= 1'b0;
      fence_wait <= 1'b0;
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
      packet_q.valid <= 1'b0;
    end else begin
      state <= state_next;
      primed <= 1'b1;
      fence_wait <= fence_wait_next;
      req_q <= req_next;
      packet_q <= packet_next;
    end
  end

  assign wb_req = req_q;
  assign packet = packet_q;

  // Request stays put until the slave answers
  a_adr_hold: assert property (@(posedge clock) disable iff (!reset)
    wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr))
    else $error("adr or stb changed before ack");

  a_ack_in_cycle: assert property (@(posedge clock) disable iff (!reset)
    wb_rsp.ack |-> wb_req.cyc)
    else $error("ack outside of a bus cycle");

endmodule

`default_nettype wire

// ==== rtl/pc_generator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module pc_generator (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::redirect_t   redirect,
  input  fetch_pkg::btc_lookup_t lookup,
  input  logic                   advance,
  output fetch_pkg::addr_t       fetch_pc,
  output logic                   redirect_pending,
  output logic                   fence_request
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_next;
  fetch_pkg::addr_t redirect_pc;

  assign redirect_pending = redirect.trap || redirect.mret || redirect.miss || redirect.fence;

  // Fence only counts when nothing stronger arrives with it
  assign fence_request = redirect.fence && !redirect.trap && !redirect.mret && !redirect.miss;

  always_comb begin
    if (redirect.trap) begin
      redirect_pc = redirect.trap_pc;
    end else if (redirect.mret) begin
      redirect_pc = redirect.mret_pc;
    end else if (redirect.miss) begin
      redirect_pc = redirect.miss_pc;
    end else begin
      redirect_pc = redirect.fence_pc;
    end
  end

  always_comb begin
    pc_next = pc_q;
    if (redirect_pending) begin
      pc_next = redirect_pc;
    end else if (advance) begin
      // Predicted taken beats sequential
      if (lookup.hit) begin
        pc_next = lookup.target;
      end else begin
        pc_next = pc_q + fetch_pkg::addr_t'(8);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q <= `FETCH_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign fetch_pc = pc_q;

  a_pc_aligned: assert property (@(posedge clock) disable iff (!reset)
    fetch_pc[2:0] == 3'b000)
    else $error("fetch pc not aligned to a fetch word");

endmodule

`default_nettype wire

// ==== rtl/branch_target_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module branch_target_cache (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::addr_t       lookup_pc,
  output fetch_pkg::btc_lookup_t lookup,
  input  fetch_pkg::btc_update_t update,
  input  fetch_pkg::btc_index_t  clear_index,
  input  logic                   clearing
);

  localparam int unsigned IDX_W = $bits(fetch_pkg::btc_index_t);
  localparam int unsigned TAG_LSB = IDX_W + 3;
  localparam int unsigned TAG_W = `FETCH_ADDR_W - TAG_LSB;

  logic [`FETCH_BTC_ENTRIES-1:0] entry_valid;
  logic [TAG_W-1:0]              entry_tag [`FETCH_BTC_ENTRIES];
  fetch_pkg::addr_t              entry_target [`FETCH_BTC_ENTRIES];

  fetch_pkg::btc_index_t lookup_index;
  logic [TAG_W-1:0]      lookup_tag;
  fetch_pkg::btc_index_t update_index;
  logic [TAG_W-1:0]      update_tag;

  // Index sits just above the byte offset of a fetch word
  assign lookup_index = lookup_pc[TAG_LSB-1:3];
  assign lookup_tag = lookup_pc[`FETCH_ADDR_W-1:TAG_LSB];
  assign update_index = update.pc[TAG_LSB-1:3];
  assign update_tag = update.pc[`FETCH_ADDR_W-1:TAG_LSB];

  always_comb begin
    lookup.hit = entry_valid[lookup_index] && (entry_tag[lookup_index] == lookup_tag);
    lookup.target = entry_target[lookup_index];
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      entry_valid <= '0;
    end else begin
      if (update.valid) begin
        entry_valid[update_index] <= 1'b1;
      end
      // Clear written last so it wins on the same entry
      if (clearing) begin
        entry_valid[clear_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (update.valid) begin
      entry_tag[update_index] <= update_tag;
      entry_target[update_index] <= update.target;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/flush_sweep_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module flush_sweep_counter (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  output fetch_pkg::btc_index_t index,
  output logic                  clearing,
  output logic                  done
);

  localparam fetch_pkg::btc_index_t LAST = fetch_pkg::btc_index_t'(`FETCH_BTC_ENTRIES - 1);

  always_ff @(posedge clock) begin
    if (!reset) begin
      index <= '0;
      clearing <= 1'b0;
    end else if (start) begin
      index <= '0;
      clearing <= 1'b1;
    end else if (clearing) begin
      index <= index + 1'b1;
      if (index == LAST) begin
        clearing <= 1'b0;
      end
    end
  end

  // Last index of the walk
  assign done = clearing && (index == LAST);

  a_no_restart: assert property (@(posedge clock) disable iff (!reset)
    start |-> !clearing)
    else $error("sweep restarted while still clearing");

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
  input  logic                     clock,
  input  logic                     reset,
  output fetch_pkg::wb_req_t       wb_req,
  input  fetch_pkg::wb_rsp_t       wb_rsp,
  input  fetch_pkg::redirect_t     redirect,
  input  fetch_pkg::btc_update_t   btc_update,
  input  logic                     stall,
  output fetch_pkg::fetch_packet_t packet
);

  fetch_pkg::addr_t       fetch_pc;
  fetch_pkg::btc_lookup_t lookup;
  fetch_pkg::btc_index_t  clear_index;
  logic                   advance;
  logic                   redirect_pending;
  logic                   fence_request;
  logic                   sweep_start;
  logic                   sweep_done;
  logic                   clearing;

  fetch_control fetch_control_inst (
    .clock            (clock),
    .reset            (reset),
    .wb_req           (wb_req),
    .wb_rsp           (wb_rsp),
    .fetch_pc         (fetch_pc),
    .lookup           (lookup),
    .redirect_pending (redirect_pending),
    .fence_request    (fence_request),
    .sweep_done       (sweep_done),
    .stall            (stall),
    .advance          (advance),
    .sweep_start      (sweep_start),
    .packet           (packet)
  );

  pc_generator pc_generator_inst (
    .clock            (clock),
    .reset            (reset),
    .redirect         (redirect),
    .lookup           (lookup),
    .advance          (advance),
    .fetch_pc         (fetch_pc),
    .redirect_pending (redirect_pending),
    .fence_request    (fence_request)
  );

  flush_sweep_counter flush_sweep_counter_inst (
    .clock    (clock),
    .reset    (reset),
    .start    (sweep_start),
    .index    (clear_index),
    .clearing (clearing),
    .done     (sweep_done)
  );

  // Looked up at the current fetch address
  branch_target_cache branch_target_cache_inst (
    .clock       (clock),
    .reset       (reset),
    .lookup_pc   (fetch_pc),
    .lookup      (lookup),
    .update      (btc_update),
    .clear_index (clear_index),
    .clearing    (clearing)
  );

endmodule

`default_nettype wire

// ==== verif/imem_wb_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module imem_wb_model (
  input  logic               clock,
  input  logic               reset,
  input  fetch_pkg::wb_req_t wb_req,
  output fetch_pkg::wb_rsp_t wb_rsp
);

  // Same latency sequence on every run
  integer     seed = 32'h562c_d00e;
  logic       busy;
  logic [1:0] remaining;

  always @(posedge clock) begin
    if (!reset) begin
      busy <= 1'b0;
      remaining <= '0;
      wb_rsp.ack <= 1'b0;
      wb_rsp.dat <= '0;
    end else if (wb_rsp.ack) begin
      // Master drops cyc on the ack edge
      wb_rsp.ack <= 1'b0;
      busy <= 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!busy) begin
        busy <= 1'b1;
        remaining <= 2'($random(seed) & 3);
      end else if (remaining == 2'd0) begin
        wb_rsp.ack <= 1'b1;
        // Address in the low half, its inverse above
        wb_rsp.dat <= {~wb_req.adr, wb_req.adr};
      end else begin
        remaining <= remaining - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/fetch_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit_tb;

  localparam int CLOCK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int NUM_ROWS = 21;
  localparam int MAX_LATENCY = 4;
  localparam int MAX_STALL = 3;
  localparam int ROW_CYCLES = 2 * (MAX_LATENCY + 3) + MAX_STALL + 2;
  localparam int WATCHDOG_CYCLES = 2 * (NUM_ROWS * ROW_CYCLES + `FETCH_BTC_ENTRIES + 8);

  typedef struct packed {
    fetch_pkg::redirect_t   redirect;
    fetch_pkg::btc_update_t update;
    logic [3:0]             stall_cycles;
    fetch_pkg::addr_t       exp_pc;
    logic                   exp_taken;
    fetch_pkg::addr_t       exp_target;
  } row_t;

  logic                     clock;
  logic                     reset;
  logic                     stall;
  fetch_pkg::wb_req_t       wb_req;
  fetch_pkg::wb_rsp_t       wb_rsp;
  fetch_pkg::redirect_t     redirect;
  fetch_pkg::btc_update_t   btc_update;
  fetch_pkg::fetch_packet_t packet;

  row_t rows [NUM_ROWS];
  int   row_count;

  fetch_unit fetch_unit_inst (
    .clock      (clock),
    .reset      (reset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .redirect   (redirect),
    .btc_update (btc_update),
    .stall      (stall),
    .packet     (packet)
  );

  imem_wb_model imem_wb_model_inst (
    .clock  (clock),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Timeout: no fetch packet arrived within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_pc(input string name, input fetch_pkg::addr_t actual,
                          input fetch_pkg::addr_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input fetch_pkg::word_t actual,
                            input fetch_pkg::word_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_taken(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: packet.taken is %b, expected %b", $time, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // Memory returns the address with its inverse above it
  function automatic fetch_pkg::word_t expected_word(input fetch_pkg::addr_t pc);
    return {~pc, pc};
  endfunction

  // Targets spread out from one base: trap, mret, miss, fence
  function automatic fetch_pkg::redirect_t make_redirect(input logic [3:0] kinds,
                                                         input fetch_pkg::addr_t base);
    fetch_pkg::redirect_t r;
    r.trap = kinds[3];
    r.trap_pc = base;
    r.mret = kinds[2];
    r.mret_pc = base + fetch_pkg::addr_t'('h100);
    r.miss = kinds[1];
    r.miss_pc = base + fetch_pkg::addr_t'('h200);
    r.fence = kinds[0];
    r.fence_pc = base + fetch_pkg::addr_t'('h300);
    return r;
  endfunction

  task automatic add_row(input logic [3:0] kinds, input fetch_pkg::addr_t base,
                         input fetch_pkg::addr_t upd_pc, input fetch_pkg::addr_t upd_target,
                         input logic [3:0] stall_cycles, input fetch_pkg::addr_t exp_pc,
                         input logic exp_taken, input fetch_pkg::addr_t exp_target);
    rows[row_count].redirect = make_redirect(kinds, base);
    rows[row_count].update.valid = (upd_pc != '0);
    rows[row_count].update.pc = upd_pc;
    rows[row_count].update.target = upd_target;
    rows[row_count].stall_cycles = stall_cycles;
    rows[row_count].exp_pc = exp_pc;
    rows[row_count].exp_taken = exp_taken;
    rows[row_count].exp_target = exp_target;
    row_count++;
  endtask

  task automatic build_table();
    row_count = 0;
    // kinds = {trap, mret, miss, fence}
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, `FETCH_RESET_PC, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, `FETCH_RESET_PC + 32'h8, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd3, `FETCH_RESET_PC + 32'h10, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, `FETCH_RESET_PC + 32'h18, 1'b0, 32'h0);
    add_row(4'b1000, 32'h2000, 32'h0, 32'h0, 4'd0, 32'h2000, 1'b0, 32'h0);
    add_row(4'b0100, 32'h2300, 32'h0, 32'h0, 4'd0, 32'h2400, 1'b0, 32'h0);
    add_row(4'b0010, 32'h2600, 32'h0, 32'h0, 4'd0, 32'h2800, 1'b0, 32'h0);
    add_row(4'b1110, 32'h3000, 32'h0, 32'h0, 4'd0, 32'h3000, 1'b0, 32'h0);
    add_row(4'b0111, 32'h3300, 32'h0, 32'h0, 4'd0, 32'h3400, 1'b0, 32'h0);
    add_row(4'b0011, 32'h3600, 32'h0, 32'h0, 4'd0, 32'h3800, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, 32'h3808, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h3818, 32'h5000, 4'd0, 32'h3810, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, 32'h3818, 1'b1, 32'h5000);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, 32'h5000, 1'b0, 32'h0);
    add_row(4'b0010, 32'h5e00, 32'h6000, 32'h7000, 4'd0, 32'h6000, 1'b1, 32'h7000);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd2, 32'h7000, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, 32'h7008, 1'b0, 32'h0);
    add_row(4'b0001, 32'h3518, 32'h0, 32'h0, 4'd0, 32'h3818, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, 32'h3820, 1'b0, 32'h0);
    add_row(4'b0010, 32'h5e00, 32'h0, 32'h0, 4'd0, 32'h6000, 1'b0, 32'h0);
    add_row(4'b0000, 32'h0, 32'h0, 32'h0, 4'd0, 32'h6008, 1'b0, 32'h0);
  endtask

  task automatic check_packet(input row_t row);
    check_flag("packet.valid", packet.valid, 1'b1);
    check_pc("packet.pc", packet.pc, row.exp_pc);
    check_word("packet.instr", packet.instr, expected_word(row.exp_pc));
    check_taken(packet.taken, row.exp_taken);
    check_pc("packet.target", packet.target, row.exp_target);
  endtask

  // Starts with a read in flight, so any redirect discards it
  task automatic run_row(input row_t row);
    redirect = row.redirect;
    btc_update = row.update;
    stall = (row.stall_cycles != 0);
    @(posedge clock);
    #DRIVE_DELAY;
    redirect = '0;
    btc_update = '0;
    while (!packet.valid) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
    check_packet(row);
    repeat (row.stall_cycles) begin
      @(posedge clock);
      #DRIVE_DELAY;
      check_packet(row);
    end
    stall = 1'b0;
    @(posedge clock);
    #DRIVE_DELAY;
    check_flag("packet.valid", packet.valid, 1'b0);
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 10);
    reset = 1'b0;
    stall = 1'b0;
    redirect = '0;
    btc_update = '0;
    build_table();
    repeat (3) begin
      @(posedge clock);
      #DRIVE_DELAY;
      check_flag("wb_req.cyc", wb_req.cyc, 1'b0);
      check_flag("wb_req.stb", wb_req.stb, 1'b0);
      check_flag("packet.valid", packet.valid, 1'b0);
    end
    reset = 1'b1;
    // One idle cycle, then the first read
    @(posedge clock);
    #DRIVE_DELAY;
    check_flag("wb_req.cyc", wb_req.cyc, 1'b0);
    @(posedge clock);
    #DRIVE_DELAY;
    check_flag("wb_req.cyc", wb_req.cyc, 1'b1);
    check_flag("wb_req.stb", wb_req.stb, 1'b1);
    check_pc("wb_req.adr", wb_req.adr, `FETCH_RESET_PC);
    for (int i = 0; i < row_count; i++) begin
      run_row(rows[i]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_control.sv
rtl/pc_generator.sv
rtl/branch_target_cache.sv
rtl/flush_sweep_counter.sv
rtl/fetch_unit.sv
verif/imem_wb_model.sv
verif/fetch_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
